// ==== list.f ====
rtl/pit_bus_pkg.sv
rtl/pit_timer_pkg.sv
rtl/pit_bus_fsm.sv
rtl/pit_regfile.sv
rtl/pit_channel.sv
rtl/pit_top.sv
testbench/pit_tb.sv

// ==== rtl/pit_bus_fsm.sv ====
`default_nettype none

// bus slave sequencer
// each cyc/stb access becomes one request strobe, then the ack is held
// until the master drops stb
module pit_bus_fsm (
	input  wire logic                             clk_i,
	input  wire logic                             rst_i,
	input  wire logic                             cyc_i,
	input  wire logic                             stb_i,
	input  wire logic                             we_i,
	input  wire logic [pit_bus_pkg::ADDR_W-1:0]   adr_i,
	input  wire logic [pit_bus_pkg::DATA_W-1:0]   dat_i,
	output pit_bus_pkg::bus_req_t                 req_o,
	output logic                                  ack_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_ACK
	} state_t;

	state_t state;

	// access captured when the strobe is first seen
	logic                           we_q;
	logic [pit_bus_pkg::ADDR_W-1:0] adr_q;
	logic [pit_bus_pkg::DATA_W-1:0] dat_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:   if (cyc_i && stb_i) state <= ST_ACCESS;
				// register file acts on this edge, ack comes up with it
				ST_ACCESS: state <= ST_ACK;
				// master holds stb for back-pressure, we just wait
				ST_ACK:    if (!stb_i) state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == ST_IDLE && cyc_i && stb_i) begin
			we_q <= we_i;
			adr_q <= adr_i;
			dat_q <= dat_i;
		end
	end

	always_comb begin
		req_o.stb = (state == ST_ACCESS);
		req_o.we = we_q;
		req_o.adr = adr_q;
		req_o.dat = dat_q;
	end

	assign ack_o = (state == ST_ACK);

	// an ack only ever answers a strobe that the master is still driving
	a_ack_needs_stb: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(ack_o) |-> $past(cyc_i && stb_i));

	// a request follows a stb sampled while ack was low, one cycle only
	// so a held stb under back-pressure never issues a second one
	a_stb_single: assert property (@(posedge clk_i) disable iff (rst_i)
		req_o.stb |-> $past(cyc_i && stb_i && !ack_o) && !$past(req_o.stb));

endmodule

`default_nettype wire

// ==== rtl/pit_bus_pkg.sv ====
`default_nettype none

// ======================================================================
// bus side definitions for the interval timer
// ======================================================================
package pit_bus_pkg;

	// word address and data widths of the slave port
	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;

	// one access as seen by the register file
	// stb is high for exactly one cycle per bus access
	typedef struct packed {
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;
	} bus_req_t;

	// per counter registers, low two bits of the word address
	// the counter index sits above them
	localparam logic [1:0] REG_COUNT  = 2'd0;
	localparam logic [1:0] REG_MAX    = 2'd1;
	localparam logic [1:0] REG_ONTIME = 2'd2;
	localparam logic [1:0] REG_CTRL   = 2'd3;

	// global registers, full word address
	localparam logic [ADDR_W-1:0] REG_UFLOW     = 12'h100;
	localparam logic [ADDR_W-1:0] REG_SYNC      = 12'h101;
	localparam logic [ADDR_W-1:0] REG_IE        = 12'h102;
	localparam logic [ADDR_W-1:0] REG_OUT       = 12'h103;
	localparam logic [ADDR_W-1:0] REG_IGATE     = 12'h104;
	localparam logic [ADDR_W-1:0] REG_IGATE_SET = 12'h105;
	localparam logic [ADDR_W-1:0] REG_IGATE_CLR = 12'h106;

	// control word bit positions
	localparam int CTRL_LD  = 0;
	localparam int CTRL_CE  = 1;
	localparam int CTRL_AR  = 2;
	localparam int CTRL_XC  = 3;
	localparam int CTRL_GE  = 4;
	localparam int CTRL_NOW = 7;

endpackage

`default_nettype wire

// ==== rtl/pit_channel.sv ====
`default_nettype none

// one down-counter of the timer block
module pit_channel #(
	parameter int BITS = 32
) (
	input  wire logic                      clk_i,
	input  wire logic                      rst_i,
	input  wire logic                      apply_i,
	input  wire pit_timer_pkg::chan_cfg_t  cfg_i,
	input  wire logic                      ext_clk_i,
	input  wire logic                      gate_i,
	input  wire logic                      igate_i,
	output pit_timer_pkg::chan_stat_t      stat_o
);

	localparam int MB = pit_timer_pkg::MAX_BITS;

	pit_timer_pkg::chan_cfg_t cfg_r;
	logic [BITS-1:0] count, max_cnt, on_time;
	logic            xclk_q, xclk_qq, xclk_rise;
	logic            gate_ok, tick, do_load, at_zero;
	logic            out_q, uf_q;

	assign max_cnt = cfg_r.max_cnt[BITS-1:0];
	assign on_time = cfg_r.on_time[BITS-1:0];

	// ======================================================================
	// tick decision
	// ======================================================================
	// external clock sampled, rising edge seen one cycle after the pin
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			xclk_q <= 1'b0;
			xclk_qq <= 1'b0;
		end else begin
			xclk_q <= ext_clk_i;
			xclk_qq <= xclk_q;
		end
	end

	assign xclk_rise = xclk_q & ~xclk_qq;
	// gate needs both the register bit and the pin
	assign gate_ok = ~cfg_r.ge | (igate_i & gate_i);
	assign tick = cfg_r.ce & (~cfg_r.xc | xclk_rise) & gate_ok;
	assign do_load = cfg_r.ld;
	assign at_zero = (count == '0);

	// ======================================================================
	// counter
	// ======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cfg_r <= '0;
			cfg_r.ar <= 1'b1;
			count <= '0;
			out_q <= 1'b0;
			uf_q <= 1'b0;
		end else begin
			uf_q <= 1'b0;
			if (do_load) begin
				count <= max_cnt;
				cfg_r.ld <= 1'b0;
			end else if (tick) begin
				if (at_zero) begin
					uf_q <= 1'b1;
					out_q <= 1'b0;
					if (cfg_r.ar) begin
						count <= max_cnt;
					end else begin
						// one-shot, wraps to all ones and stops
						count <= count - 1'b1;
						cfg_r.ce <= 1'b0;
					end
				end else begin
					count <= count - 1'b1;
					if (count == on_time) out_q <= 1'b1;
				end
			end
			// a new configuration overrides the self-clearing bits above
			if (apply_i) cfg_r <= cfg_i;
		end
	end

	always_comb begin
		stat_o.count = MB'(count);
		stat_o.out = out_q;
		stat_o.ce = cfg_r.ce;
		stat_o.uf = uf_q;
	end

	// load takes priority over any tick and is gone one cycle later
	a_load_no_dec: assert property (@(posedge clk_i) disable iff (rst_i)
		do_load && !apply_i |=> count == $past(max_cnt) && !cfg_r.ld);

endmodule

`default_nettype wire

// ==== rtl/pit_regfile.sv ====
`default_nettype none

// register file of the timer block
// holding registers, apply and sync, status, interrupt and gate control
module pit_regfile #(
	parameter int NTIMER = 4,
	parameter int BITS = 32
) (
	input  wire logic                                    clk_i,
	input  wire logic                                    rst_i,
	input  wire pit_bus_pkg::bus_req_t                   req_i,
	input  wire pit_timer_pkg::chan_stat_t [NTIMER-1:0]  stat_i,
	output logic [NTIMER-1:0]                            apply_o,
	output pit_timer_pkg::chan_cfg_t [NTIMER-1:0]        cfg_o,
	output logic [NTIMER-1:0]                            igate_o,
	output logic [pit_bus_pkg::DATA_W-1:0]               dat_o,
	output logic                                         irq_o
);

	localparam int DW = pit_bus_pkg::DATA_W;
	localparam int MB = pit_timer_pkg::MAX_BITS;
	// mode bits after reset, auto-reload only
	localparam logic [4:0] MODE_RST = 5'(1 << pit_bus_pkg::CTRL_AR);

	// holding values, written by the bus and copied on apply
	logic [BITS-1:0]   max_h [NTIMER];
	logic [BITS-1:0]   ont_h [NTIMER];
	logic [NTIMER-1:0] ld_h, ce_h, ar_h, xc_h, ge_h;

	logic [NTIMER-1:0] ie, underflow, irqf, igate;
	logic [NTIMER-1:0] uf_vec, out_vec, sel, ctrl_wr, uf_clr;
	logic              wr, sync_wr;
	logic [1:0]        reg_sel;
	logic [DW-1:0]     wdat, rd_data;

	// builds an applied configuration, mode bits in control word order
	function automatic pit_timer_pkg::chan_cfg_t pack_cfg(input logic [BITS-1:0] mx,
			input logic [BITS-1:0] on, input logic [4:0] mode);
		pit_timer_pkg::chan_cfg_t c;
		c.max_cnt = MB'(mx);
		c.on_time = MB'(on);
		c.ld = mode[pit_bus_pkg::CTRL_LD];
		c.ce = mode[pit_bus_pkg::CTRL_CE];
		c.ar = mode[pit_bus_pkg::CTRL_AR];
		c.xc = mode[pit_bus_pkg::CTRL_XC];
		c.ge = mode[pit_bus_pkg::CTRL_GE];
		return c;
	endfunction

	// ======================================================================
	// address decode
	// ======================================================================
	assign wr = req_i.stb & req_i.we;
	assign wdat = req_i.dat;
	assign reg_sel = req_i.adr[1:0];
	assign sync_wr = wr && req_i.adr == pit_bus_pkg::REG_SYNC;
	// a set bit in the status write acks that counter
	assign uf_clr = (wr && req_i.adr == pit_bus_pkg::REG_UFLOW) ? wdat[NTIMER-1:0] : '0;

	always_comb begin
		for (int n = 0; n < NTIMER; n++) begin
			// globals sit above every counter index, so they never match here
			sel[n] = (req_i.adr[pit_bus_pkg::ADDR_W-1:2] == n);
			ctrl_wr[n] = wr && sel[n] && reg_sel == pit_bus_pkg::REG_CTRL;
			uf_vec[n] = stat_i[n].uf;
			out_vec[n] = stat_i[n].out;
		end
	end

	// ======================================================================
	// holding registers and apply
	// ======================================================================
	always_ff @(posedge clk_i) begin
		for (int n = 0; n < NTIMER; n++) begin
			if (wr && sel[n] && reg_sel == pit_bus_pkg::REG_MAX) max_h[n] <= wdat[BITS-1:0];
			if (wr && sel[n] && reg_sel == pit_bus_pkg::REG_ONTIME) ont_h[n] <= wdat[BITS-1:0];
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ld_h <= '0;
			ce_h <= '0;
			ar_h <= '1;
			xc_h <= '0;
			ge_h <= '0;
			apply_o <= '0;
			for (int n = 0; n < NTIMER; n++) begin
				cfg_o[n] <= pack_cfg('0, '0, MODE_RST);
			end
		end else begin
			apply_o <= '0;
			for (int n = 0; n < NTIMER; n++) begin
				if (ctrl_wr[n]) begin
					// a load applied right away is used up, don't keep it for a sync
					ld_h[n] <= wdat[pit_bus_pkg::CTRL_LD] & ~wdat[pit_bus_pkg::CTRL_NOW];
					ce_h[n] <= wdat[pit_bus_pkg::CTRL_CE];
					ar_h[n] <= wdat[pit_bus_pkg::CTRL_AR];
					xc_h[n] <= wdat[pit_bus_pkg::CTRL_XC];
					ge_h[n] <= wdat[pit_bus_pkg::CTRL_GE];
					if (wdat[pit_bus_pkg::CTRL_NOW]) begin
						apply_o[n] <= 1'b1;
						cfg_o[n] <= pack_cfg(max_h[n], ont_h[n], wdat[4:0]);
					end
				end
				// sync write starts every selected counter on the same edge
				if (sync_wr && wdat[n]) begin
					apply_o[n] <= 1'b1;
					cfg_o[n] <= pack_cfg(max_h[n], ont_h[n],
						{ge_h[n], xc_h[n], ar_h[n], ce_h[n], ld_h[n]});
					ld_h[n] <= 1'b0;
				end
			end
		end
	end

	// ======================================================================
	// status, interrupts and internal gate
	// ======================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ie <= '0;
			underflow <= '0;
			irqf <= '0;
			igate <= '0;
		end else begin
			if (wr) begin
				case (req_i.adr)
					pit_bus_pkg::REG_IE:        ie <= wdat[NTIMER-1:0];
					pit_bus_pkg::REG_IGATE:     igate <= wdat[NTIMER-1:0];
					pit_bus_pkg::REG_IGATE_SET: igate <= igate | wdat[NTIMER-1:0];
					pit_bus_pkg::REG_IGATE_CLR: igate <= igate & ~wdat[NTIMER-1:0];
					default: ;
				endcase
			end
			// acking a counter also masks its interrupt until re-enabled
			if (|uf_clr) ie <= ie & ~uf_clr;
			// a fresh underflow wins over a clear in the same cycle
			underflow <= (underflow & ~uf_clr) | uf_vec;
			irqf <= (irqf & ~uf_clr) | (uf_vec & ie);
		end
	end

	assign igate_o = igate;
	assign irq_o = |irqf;

	// ======================================================================
	// read mux
	// ======================================================================
	always_comb begin
		rd_data = '0;
		case (req_i.adr)
			pit_bus_pkg::REG_UFLOW: rd_data = DW'(underflow);
			pit_bus_pkg::REG_IE:    rd_data = DW'(ie);
			pit_bus_pkg::REG_OUT:   rd_data = DW'(out_vec);
			pit_bus_pkg::REG_IGATE: rd_data = DW'(igate);
			default: begin
				for (int n = 0; n < NTIMER; n++) begin
					if (sel[n]) begin
						case (reg_sel)
							pit_bus_pkg::REG_COUNT:  rd_data = DW'(stat_i[n].count);
							pit_bus_pkg::REG_MAX:    rd_data = DW'(max_h[n]);
							pit_bus_pkg::REG_ONTIME: rd_data = DW'(ont_h[n]);
							default: begin
								// live enable, applied mode bits, load reads 0
								rd_data[pit_bus_pkg::CTRL_CE] = stat_i[n].ce;
								rd_data[pit_bus_pkg::CTRL_AR] = cfg_o[n].ar;
								rd_data[pit_bus_pkg::CTRL_XC] = cfg_o[n].xc;
								rd_data[pit_bus_pkg::CTRL_GE] = cfg_o[n].ge;
							end
						endcase
					end
				end
			end
		endcase
	end

	// read data held until the next read
	always_ff @(posedge clk_i) begin
		if (req_i.stb && !req_i.we) dat_o <= rd_data;
	end

	// only a bus write may start a counter configuration
	a_apply_after_write: assert property (@(posedge clk_i) disable iff (rst_i)
		|apply_o |-> $past(wr));

endmodule

`default_nettype wire

// ==== rtl/pit_timer_pkg.sv ====
`default_nettype none

// ======================================================================
// counter side definitions for the interval timer
// ======================================================================
package pit_timer_pkg;

	// widest count the bus can return in one word
	localparam int MAX_BITS = 32;

	// configuration handed to a counter when it is applied
	// only the low BITS of the wide fields are used
	typedef struct packed {
		logic [MAX_BITS-1:0] max_cnt;
		logic [MAX_BITS-1:0] on_time;
		// load max count, clears itself in the counter
		logic                ld;
		// count enable
		logic                ce;
		// reload on underflow, else stop
		logic                ar;
		// count external clock edges
		logic                xc;
		// honour the gate
		logic                ge;
	} chan_cfg_t;

	// what a counter reports back
	typedef struct packed {
		logic [MAX_BITS-1:0] count;
		// output pin level
		logic                out;
		// live enable, drops on a one-shot underflow
		logic                ce;
		// single cycle underflow pulse
		logic                uf;
	} chan_stat_t;

endpackage

`default_nettype wire

// ==== rtl/pit_top.sv ====
`default_nettype none

// programmable interval timer, NTIMER counters behind a cyc/stb slave
module pit_top #(
	parameter int NTIMER = 4,
	parameter int BITS = 32
) (
	input  wire logic                            clk_i,
	input  wire logic                            rst_i,
	input  wire logic                            cyc_i,
	input  wire logic                            stb_i,
	input  wire logic                            we_i,
	input  wire logic [pit_bus_pkg::ADDR_W-1:0]  adr_i,
	input  wire logic [pit_bus_pkg::DATA_W-1:0]  dat_i,
	output logic                                 ack_o,
	output logic [pit_bus_pkg::DATA_W-1:0]       dat_o,
	input  wire logic [NTIMER-1:0]               ext_clk_i,
	input  wire logic [NTIMER-1:0]               gate_i,
	output logic [NTIMER-1:0]                    out_o,
	output logic                                 irq_o
);

	pit_bus_pkg::bus_req_t                 req;
	logic [NTIMER-1:0]                     apply, igate;
	pit_timer_pkg::chan_cfg_t [NTIMER-1:0]  cfg;
	pit_timer_pkg::chan_stat_t [NTIMER-1:0] stat;

	pit_bus_fsm u_bus (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.req_o(req),
		.ack_o(ack_o)
	);

	pit_regfile #(
		.NTIMER(NTIMER),
		.BITS(BITS)
	) u_regs (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.req_i(req),
		.stat_i(stat),
		.apply_o(apply),
		.cfg_o(cfg),
		.igate_o(igate),
		.dat_o(dat_o),
		.irq_o(irq_o)
	);

	// ======================================================================
	// counters
	// ======================================================================
	for (genvar g = 0; g < NTIMER; g++) begin : g_chan
		pit_channel #(
			.BITS(BITS)
		) u_chan (
			.clk_i(clk_i),
			.rst_i(rst_i),
			.apply_i(apply[g]),
			.cfg_i(cfg[g]),
			.ext_clk_i(ext_clk_i[g]),
			.gate_i(gate_i[g]),
			.igate_i(igate[g]),
			.stat_o(stat[g])
		);
		assign out_o[g] = stat[g].out;
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the timer testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pit_tb \
	-f list.f --Mdir obj_dir -o pit_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/pit_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== testbench/pit_tb.sv ====
`default_nettype none

module pit_tb;

	localparam int NTIMER = 4;
	localparam int BITS = 32;
	localparam int AW = pit_bus_pkg::ADDR_W;
	localparam int DW = pit_bus_pkg::DATA_W;
	localparam int ACK_LIMIT = 20;
	localparam int POLL_LIMIT = 40;
	localparam int IRQ_LIMIT = 100;
	// worst case of one access: full ack wait plus the release cycles
	localparam int ACC_CYC = ACK_LIMIT + 2;
	localparam int TEST_CYC = 5 + 16 * ACC_CYC + (5 + POLL_LIMIT) * ACC_CYC
		+ 9 * ACC_CYC + IRQ_LIMIT + (16 + POLL_LIMIT) * ACC_CYC + 10 * ACC_CYC + 17 * 4 + 4;
	localparam int WATCHDOG_CYC = 2 * TEST_CYC;

	// control word bits
	localparam logic [DW-1:0] C_LD = DW'(1) << pit_bus_pkg::CTRL_LD;
	localparam logic [DW-1:0] C_CE = DW'(1) << pit_bus_pkg::CTRL_CE;
	localparam logic [DW-1:0] C_AR = DW'(1) << pit_bus_pkg::CTRL_AR;
	localparam logic [DW-1:0] C_XC = DW'(1) << pit_bus_pkg::CTRL_XC;
	localparam logic [DW-1:0] C_GE = DW'(1) << pit_bus_pkg::CTRL_GE;
	localparam logic [DW-1:0] C_NOW = DW'(1) << pit_bus_pkg::CTRL_NOW;

	logic              clk_i, rst_i, cyc_i, stb_i, we_i, ack_o, irq_o;
	logic [AW-1:0]     adr_i;
	logic [DW-1:0]     dat_i, dat_o;
	logic [NTIMER-1:0] ext_clk_i, gate_i, out_o;
	logic [DW-1:0]     max_v [NTIMER];
	logic [DW-1:0]     on_v [NTIMER];
	int                checks, errors;

	pit_top #(
		.NTIMER(NTIMER),
		.BITS(BITS)
	) pit_top_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.ack_o(ack_o),
		.dat_o(dat_o),
		.ext_clk_i(ext_clk_i),
		.gate_i(gate_i),
		.out_o(out_o),
		.irq_o(irq_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// ======================================================================
	// bus and pin helpers, all entered and left 1 unit after an edge
	// ======================================================================
	task automatic next_cycle();
		@(posedge clk_i);
		#1;
	endtask

	function automatic logic [AW-1:0] chan_adr(input int n, input logic [1:0] r);
		return AW'(n * 4) | AW'(r);
	endfunction

	// four-phase exchange, stb dropped only once ack is seen
	task automatic bus_cycle(input logic we, input logic [AW-1:0] adr,
			input logic [DW-1:0] wdat, output logic [DW-1:0] rdat);
		int n;
		n = 0;
		rdat = '0;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = we;
		adr_i = adr;
		dat_i = wdat;
		do begin
			next_cycle();
			n++;
		end while (!ack_o && n < ACK_LIMIT);
		if (!ack_o) begin
			$display("bus access to 0x%h got no ack within %0d cycles", adr, ACK_LIMIT);
			errors++;
		end else begin
			rdat = dat_o;
		end
		stb_i = 1'b0;
		cyc_i = 1'b0;
		we_i = 1'b0;
		next_cycle();
		if (ack_o !== 1'b0) begin
			$display("ack still high one cycle after stb dropped, address 0x%h", adr);
			errors++;
		end
	endtask

	task automatic bus_write(input logic [AW-1:0] adr, input logic [DW-1:0] wdat);
		logic [DW-1:0] unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input logic [AW-1:0] adr, output logic [DW-1:0] rdat);
		bus_cycle(1'b0, adr, '0, rdat);
	endtask

	task automatic check_word(input string name, input logic [DW-1:0] got,
			input logic [DW-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bits(input string name, input logic [NTIMER-1:0] got,
			input logic [NTIMER-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pin(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic read_check(input string name, input logic [AW-1:0] adr,
			input logic [DW-1:0] exp);
		logic [DW-1:0] rd;
		bus_read(adr, rd);
		check_word(name, rd, exp);
	endtask

	// poll the sticky underflow word until every bit of mask is set
	task automatic wait_uflow(input logic [NTIMER-1:0] mask);
		logic [DW-1:0] rd;
		int n;
		n = 0;
		do begin
			bus_read(pit_bus_pkg::REG_UFLOW, rd);
			n++;
		end while ((rd[NTIMER-1:0] & mask) != mask && n < POLL_LIMIT);
		if ((rd[NTIMER-1:0] & mask) != mask) begin
			$display("underflow of counters 0x%h not seen after %0d polls", mask, POLL_LIMIT);
			errors++;
		end
	endtask

	task automatic pulse_ext(input int ch, input int count);
		for (int i = 0; i < count; i++) begin
			ext_clk_i[ch] = 1'b1;
			repeat (2) next_cycle();
			ext_clk_i[ch] = 1'b0;
			repeat (2) next_cycle();
		end
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================
	task automatic test_register_access();
		for (int n = 0; n < NTIMER; n++) begin
			// max from 2 to 63, on time strictly between 0 and max
			// so the output pin rises before every underflow
			max_v[n] = DW'(2 + $urandom % 62);
			on_v[n] = DW'(1 + $urandom % (max_v[n] - 1));
			bus_write(chan_adr(n, pit_bus_pkg::REG_MAX), max_v[n]);
			bus_write(chan_adr(n, pit_bus_pkg::REG_ONTIME), on_v[n]);
		end
		for (int n = 0; n < NTIMER; n++) begin
			read_check("max count", chan_adr(n, pit_bus_pkg::REG_MAX), max_v[n]);
			read_check("on time", chan_adr(n, pit_bus_pkg::REG_ONTIME), on_v[n]);
		end
	endtask

	// counter 0 counts its random max down once and stops
	task automatic test_one_shot();
		bus_write(chan_adr(0, pit_bus_pkg::REG_CTRL), C_LD | C_CE | C_NOW);
		wait_uflow(4'b0001);
		read_check("count 0", chan_adr(0, pit_bus_pkg::REG_COUNT), DW'({BITS{1'b1}}));
		read_check("control 0", chan_adr(0, pit_bus_pkg::REG_CTRL), '0);
		check_bits("out_o[0]", out_o & 4'b0001, 4'b0000);
		read_check("underflow status", pit_bus_pkg::REG_UFLOW, DW'(4'b0001));
		bus_write(pit_bus_pkg::REG_UFLOW, DW'(4'b0001));
	endtask

	task automatic test_interrupt();
		int n;
		n = 0;
		bus_write(chan_adr(3, pit_bus_pkg::REG_MAX), 32'd8);
		bus_write(chan_adr(3, pit_bus_pkg::REG_ONTIME), 32'd3);
		bus_write(pit_bus_pkg::REG_IE, DW'(4'b1011));
		bus_write(chan_adr(3, pit_bus_pkg::REG_CTRL), C_LD | C_CE | C_AR | C_NOW);
		while (!irq_o && n < IRQ_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!irq_o) begin
			$display("irq_o did not rise within %0d cycles", IRQ_LIMIT);
			errors++;
		end
		// stop the counter so no fresh underflow lands after the clear
		bus_write(chan_adr(3, pit_bus_pkg::REG_CTRL), C_AR | C_NOW);
		bus_write(pit_bus_pkg::REG_UFLOW, DW'(4'b1000));
		check_pin("irq_o", irq_o, 1'b0);
		read_check("underflow status", pit_bus_pkg::REG_UFLOW, '0);
		read_check("interrupt enable", pit_bus_pkg::REG_IE, DW'(4'b0011));
		bus_write(pit_bus_pkg::REG_IE, '0);
	endtask

	task automatic test_sync_start();
		bus_write(chan_adr(1, pit_bus_pkg::REG_MAX), 32'd12);
		bus_write(chan_adr(1, pit_bus_pkg::REG_ONTIME), 32'd4);
		bus_write(chan_adr(2, pit_bus_pkg::REG_MAX), 32'd20);
		bus_write(chan_adr(2, pit_bus_pkg::REG_ONTIME), 32'd6);
		for (int n = 1; n <= 2; n++) begin
			bus_write(chan_adr(n, pit_bus_pkg::REG_CTRL), C_LD | C_CE | C_AR);
		end
		for (int n = 1; n <= 2; n++) begin
			read_check("held count", chan_adr(n, pit_bus_pkg::REG_COUNT), '0);
			// mode bits still the reset configuration
			read_check("held control", chan_adr(n, pit_bus_pkg::REG_CTRL), C_AR);
		end
		bus_write(pit_bus_pkg::REG_SYNC, DW'(4'b0110));
		for (int n = 1; n <= 2; n++) begin
			read_check("synced control", chan_adr(n, pit_bus_pkg::REG_CTRL), C_AR | C_CE);
		end
		wait_uflow(4'b0110);
		for (int n = 1; n <= 2; n++) begin
			bus_write(chan_adr(n, pit_bus_pkg::REG_CTRL), C_AR | C_NOW);
		end
		bus_write(pit_bus_pkg::REG_UFLOW, DW'(4'b0110));
	endtask

	// counter 0 on its external clock, max 10 on time 5
	task automatic test_ext_clock_gate();
		gate_i[0] = 1'b1;
		bus_write(chan_adr(0, pit_bus_pkg::REG_MAX), 32'd10);
		bus_write(chan_adr(0, pit_bus_pkg::REG_ONTIME), 32'd5);
		bus_write(pit_bus_pkg::REG_IGATE_CLR, DW'(4'b0001));
		bus_write(chan_adr(0, pit_bus_pkg::REG_CTRL), C_LD | C_CE | C_AR | C_XC | C_GE | C_NOW);
		repeat (4) next_cycle();
		// internal gate bit closed, pulses ignored
		pulse_ext(0, 6);
		read_check("gated count", chan_adr(0, pit_bus_pkg::REG_COUNT), 32'd10);
		bus_write(pit_bus_pkg::REG_IGATE_SET, DW'(4'b0001));
		pulse_ext(0, 6);
		read_check("count after 6", chan_adr(0, pit_bus_pkg::REG_COUNT), 32'd4);
		check_bits("out_o[0]", out_o & 4'b0001, 4'b0001);
		// one decrement per pulse from 4 down to 0
		pulse_ext(0, 4);
		read_check("count at zero", chan_adr(0, pit_bus_pkg::REG_COUNT), '0);
		pulse_ext(0, 1);
		read_check("reloaded count", chan_adr(0, pit_bus_pkg::REG_COUNT), 32'd10);
		check_bits("out_o[0]", out_o & 4'b0001, 4'b0000);
		read_check("underflow status", pit_bus_pkg::REG_UFLOW, DW'(4'b0001));
	endtask

	// ======================================================================
	// run control
	// ======================================================================
	initial begin
		#(WATCHDOG_CYC * 10);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYC);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(73423));
		checks = 0;
		errors = 0;
		rst_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		ext_clk_i = '0;
		gate_i = '0;
		repeat (4) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		next_cycle();
		test_register_access();
		test_one_shot();
		test_interrupt();
		test_sync_start();
		test_ext_clock_gate();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
